// File: cgra_data_pkg.sv
// ======================================================================
// Datapath types shared by the PEs, the ALU and the array top level.
// DATA_W is fixed here, so a wider datapath means editing this package.
// Ready is not part of strm_t and travels against the data.
// ======================================================================

package cgra_data_pkg;

    // Datapath width of every link and register
    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] data_t;

    // One forward link of the mesh
    typedef struct packed {
        logic  valid;
        data_t data;
    } strm_t;

endpackage

// File: cgra_cfg_pkg.sv
// ======================================================================
// Configuration types: opcodes, operand selects, the per-PE config word
// and the 32-bit bitstream word. The PE index is row * COLS + column.
// ======================================================================

package cgra_cfg_pkg;

    localparam int IMM_W    = 16;
    localparam int PE_IDX_W = 8;

    typedef logic [IMM_W-1:0]    imm_t;
    typedef logic [PE_IDX_W-1:0] pe_idx_t;

    // MUL keeps the low half, SHL uses b[4:0], PASS returns a
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_SHL  = 3'd6,
        OP_PASS = 3'd7
    } op_e;

    typedef enum logic {
        ASEL_NORTH = 1'b0,
        ASEL_WEST  = 1'b1
    } asel_e;

    typedef enum logic [1:0] {
        BSEL_NORTH = 2'd0,
        BSEL_WEST  = 2'd1,
        BSEL_IMM   = 2'd2
    } bsel_e;

    typedef enum logic {
        DIR_SOUTH = 1'b0,
        DIR_EAST  = 1'b1
    } dir_e;

    // 23 bits
    typedef struct packed {
        op_e   op;
        asel_e a_sel;
        bsel_e b_sel;
        dir_e  out_dir;
        imm_t  imm;
    } pe_cfg_t;

    // 32 bits, write flag in the MSB
    typedef struct packed {
        logic    write;
        pe_idx_t pe_idx;
        pe_cfg_t cfg;
    } bitstream_t;

endpackage

// File: cgra_pe_alu.sv
// ======================================================================
// Combinational operation unit of one PE. All arithmetic wraps at
// 32 bits. The immediate is already extended to data_t by the caller.
// ======================================================================
`timescale 1ns/1ps

module cgra_pe_alu (
    input  cgra_cfg_pkg::op_e    op_i,
    input  cgra_data_pkg::data_t a_i,
    input  cgra_data_pkg::data_t b_i,
    output cgra_data_pkg::data_t result_o
);

    import cgra_cfg_pkg::*;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = a_i + b_i;
            end
            OP_SUB: begin
                result_o = a_i - b_i;
            end
            // Low half of the product
            OP_MUL: begin
                result_o = a_i * b_i;
            end
            OP_AND: begin
                result_o = a_i & b_i;
            end
            OP_OR: begin
                result_o = a_i | b_i;
            end
            OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            OP_SHL: begin
                result_o = a_i << b_i[4:0];
            end
            default: begin
                result_o = a_i;
            end
        endcase
    end

endmodule

// File: cgra_pe.sv
// ======================================================================
// Processing element with one output register. Only the inputs named
// by the operand selects are joined and made ready. Output shows on
// the configured side only, and nothing moves while run_i is low.
// ======================================================================
`timescale 1ns/1ps

module cgra_pe (
    input  logic                    clk,
    input  logic                    rst_n_bs,
    input  logic                    catch_i,
    input  cgra_cfg_pkg::pe_cfg_t   cfg_i,
    input  logic                    run_i,
    input  cgra_data_pkg::strm_t    north_i,
    output logic                    north_ready_o,
    input  cgra_data_pkg::strm_t    west_i,
    output logic                    west_ready_o,
    output cgra_data_pkg::strm_t    south_o,
    input  logic                    south_ready_i,
    output cgra_data_pkg::strm_t    east_o,
    input  logic                    east_ready_i
);

    import cgra_data_pkg::*;
    import cgra_cfg_pkg::*;

    pe_cfg_t cfg_q;
    logic    need_n;
    logic    need_w;
    logic    in_ok;
    logic    out_ready;
    logic    out_pres;
    logic    drain;
    logic    load;
    data_t   op_a;
    data_t   op_b;
    data_t   alu_result;
    logic    out_valid_q;
    data_t   out_data_q;

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            cfg_q <= '0;
        end else if (catch_i) begin
            cfg_q <= cfg_i;
        end
    end

    // One input may feed both operands
    assign need_n = (cfg_q.a_sel == ASEL_NORTH) || (cfg_q.b_sel == BSEL_NORTH);
    assign need_w = (cfg_q.a_sel == ASEL_WEST) || (cfg_q.b_sel == BSEL_WEST);
    assign in_ok  = (!need_n || north_i.valid) && (!need_w || west_i.valid);

    assign out_ready = (cfg_q.out_dir == DIR_SOUTH) ? south_ready_i : east_ready_i;
    assign out_pres  = out_valid_q && run_i;
    assign drain     = out_pres && out_ready;
    assign load      = run_i && in_ok && (!out_valid_q || drain);

    assign north_ready_o = load && need_n;
    assign west_ready_o  = load && need_w;

    assign op_a = (cfg_q.a_sel == ASEL_NORTH) ? north_i.data : west_i.data;

    always_comb begin
        case (cfg_q.b_sel)
            BSEL_NORTH: op_b = north_i.data;
            BSEL_WEST:  op_b = west_i.data;
            // Sign-extended immediate
            default:    op_b = {{(DATA_W-IMM_W){cfg_q.imm[IMM_W-1]}}, cfg_q.imm};
        endcase
    end

    cgra_pe_alu alu_inst (
        .op_i     (cfg_q.op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            out_valid_q <= 1'b0;
        end else if (load) begin
            out_valid_q <= 1'b1;
        end else if (drain) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data_q <= alu_result;
        end
    end

    assign south_o.valid = out_pres && (cfg_q.out_dir == DIR_SOUTH);
    assign south_o.data  = out_data_q;
    assign east_o.valid  = out_pres && (cfg_q.out_dir == DIR_EAST);
    assign east_o.data   = out_data_q;

    // A stalled item stays put until the consumer takes it
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n_bs)
        (out_pres && !out_ready) |=> (out_valid_q && $stable(out_data_q))
    );

endmodule

// File: cgra_cfg_decoder.sv
// ======================================================================
// Bitstream decoder. Capture strobes are combinational from the word.
// Configured flags are sticky until reset, so run enables follow one
// cycle after the first write to a PE. ROWS * COLS must fit in pe_idx_t.
// ======================================================================
`timescale 1ns/1ps

module cgra_cfg_decoder #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n_bs,
    input  cgra_cfg_pkg::bitstream_t   bitstream_i,
    input  logic                       bitstream_enable_i,
    input  logic                       execute_i,
    output logic [ROWS*COLS-1:0]       catch_o,
    output cgra_cfg_pkg::pe_cfg_t      cfg_o,
    output logic [ROWS*COLS-1:0]       run_o
);

    import cgra_cfg_pkg::*;

    localparam int N_PE = ROWS * COLS;

    logic            wr_valid;
    logic [N_PE-1:0] configured_q;

    assign wr_valid = bitstream_enable_i && bitstream_i.write;

    // Index compare against every PE
    always_comb begin
        for (int i = 0; i < N_PE; i++) begin
            catch_o[i] = wr_valid && (bitstream_i.pe_idx == pe_idx_t'(i));
        end
    end

    // Payload is broadcast, only the strobed PE takes it
    assign cfg_o = bitstream_i.cfg;

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            configured_q <= '0;
        end else begin
            configured_q <= configured_q | catch_o;
        end
    end

    assign run_o = configured_q & {N_PE{execute_i}};

    // Writes beyond the grid would be dropped silently
    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n_bs)
        wr_valid |-> (int'(bitstream_i.pe_idx) < N_PE)
    );

    // Last-column PEs have no consumer to the east
    a_no_east_edge: assert property (
        @(posedge clk) disable iff (!rst_n_bs)
        (wr_valid && ((int'(bitstream_i.pe_idx) % COLS) == COLS - 1))
            |-> (bitstream_i.cfg.out_dir != DIR_EAST)
    );

endmodule

// File: cgra_top.sv
// ======================================================================
// CGRA array top level. Streams enter row 0 from the north and leave
// the last row to the south. Column 0 west inputs are tied invalid and
// last-column east outputs see no ready, so never configure DIR_EAST.
// ======================================================================
`timescale 1ns/1ps

module cgra_top #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n_bs,
    input  cgra_data_pkg::strm_t [COLS-1:0]      data_i,
    output logic [COLS-1:0]                      data_ready_o,
    output cgra_data_pkg::strm_t [COLS-1:0]      data_o,
    input  logic [COLS-1:0]                      data_ready_i,
    input  cgra_cfg_pkg::bitstream_t             bitstream_i,
    input  logic                                 bitstream_enable_i,
    input  logic                                 execute_i
);

    import cgra_data_pkg::*;
    import cgra_cfg_pkg::*;

    localparam int N_PE = ROWS * COLS;

    logic [N_PE-1:0] catch;
    logic [N_PE-1:0] run;
    pe_cfg_t         cfg;

    // ns_link[r] enters row r from above, ns_link[ROWS] leaves the array
    strm_t [ROWS:0][COLS-1:0]   ns_link;
    logic  [ROWS:0][COLS-1:0]   ns_ready;
    // we_link[r][c] enters column c from the left
    strm_t [ROWS-1:0][COLS:0]   we_link;
    logic  [ROWS-1:0][COLS:0]   we_ready;

    cgra_cfg_decoder #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) cfg_decoder_inst (
        .clk                (clk),
        .rst_n_bs           (rst_n_bs),
        .bitstream_i        (bitstream_i),
        .bitstream_enable_i (bitstream_enable_i),
        .execute_i          (execute_i),
        .catch_o            (catch),
        .cfg_o              (cfg),
        .run_o              (run)
    );

    // North and south edges
    assign ns_link[0]     = data_i;
    assign data_ready_o   = ns_ready[0];
    assign data_o         = ns_link[ROWS];
    assign ns_ready[ROWS] = data_ready_i;

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        // West and east edge tie-offs
        assign we_link[r][0]     = '0;
        assign we_ready[r][COLS] = 1'b0;

        for (genvar c = 0; c < COLS; c++) begin : g_col
            cgra_pe pe_inst (
                .clk           (clk),
                .rst_n_bs      (rst_n_bs),
                .catch_i       (catch[r*COLS+c]),
                .cfg_i         (cfg),
                .run_i         (run[r*COLS+c]),
                .north_i       (ns_link[r][c]),
                .north_ready_o (ns_ready[r][c]),
                .west_i        (we_link[r][c]),
                .west_ready_o  (we_ready[r][c]),
                .south_o       (ns_link[r+1][c]),
                .south_ready_i (ns_ready[r+1][c]),
                .east_o        (we_link[r][c+1]),
                .east_ready_i  (we_ready[r][c+1])
            );
        end
    end

endmodule

// File: tb_cgra_tasks.svh
// ======================================================================
// Drive, configure and compare tasks for the CGRA testbench. Included
// inside tb_cgra_top, so they use its signals, queues and error count.
// ======================================================================
`ifndef TB_CGRA_TASKS_SVH
`define TB_CGRA_TASKS_SVH

task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

// One bitstream word, held for a single cycle
task automatic configure_pe(input int idx, input op_e op, input asel_e a_sel,
                            input bsel_e b_sel, input dir_e out_dir, input imm_t imm);
    @(negedge clk);
    bitstream_i.write       = 1'b1;
    bitstream_i.pe_idx      = pe_idx_t'(idx);
    bitstream_i.cfg.op      = op;
    bitstream_i.cfg.a_sel   = a_sel;
    bitstream_i.cfg.b_sel   = b_sel;
    bitstream_i.cfg.out_dir = out_dir;
    bitstream_i.cfg.imm     = imm;
    bitstream_enable_i      = 1'b1;
    @(negedge clk);
    bitstream_enable_i = 1'b0;
    bitstream_i        = '0;
endtask

// Holds each word until the array takes it
task automatic send_column(input int col);
    data_t w;
    while (send_q[col].size() > 0) begin
        w = send_q[col].pop_front();
        @(negedge clk);
        data_i[col].valid = 1'b1;
        data_i[col].data  = w;
        #2;
        while (!data_ready_o[col]) begin
            @(negedge clk);
            #2;
        end
    end
    @(negedge clk);
    data_i[col].valid = 1'b0;
endtask

task automatic expect_column(input int col, input int count);
    int    got_n;
    logic  stalled;
    data_t held;
    got_n   = 0;
    stalled = 1'b0;
    held    = '0;
    while (got_n < count) begin
        @(negedge clk);
        #2;
        // A stalled word must still be there, unchanged
        if (stalled) begin
            check_bit($sformatf("data_o[%0d].valid", col), data_o[col].valid, 1'b1);
            check_data($sformatf("data_o[%0d].data", col), data_o[col].data, held);
        end
        if (data_o[col].valid && data_ready_i[col]) begin
            check_data($sformatf("data_o[%0d].data", col), data_o[col].data,
                       exp_q[col].pop_front());
            got_n++;
            stalled = 1'b0;
        end else begin
            stalled = data_o[col].valid;
            held    = data_o[col].data;
        end
    end
    // No extra word may follow the last one
    repeat (ROWS) begin
        @(negedge clk);
        #2;
        check_bit($sformatf("data_o[%0d].valid", col), data_o[col].valid, 1'b0);
    end
endtask

`endif

// File: tb_cgra_top.sv
// ======================================================================
// Directed testbench for the 4 x 4 CGRA. Keeps its own expected-value
// queues per output column. Runs are limited by a cycle timeout.
// ======================================================================
`timescale 1ns/1ps

module tb_cgra_top;

    import cgra_data_pkg::*;
    import cgra_cfg_pkg::*;

    localparam int ROWS    = 4;
    localparam int COLS    = 4;
    localparam int TIMEOUT = 6000;

    logic                  clk;
    logic                  rst_n_bs;
    strm_t [COLS-1:0]      data_i;
    logic  [COLS-1:0]      data_ready_o;
    strm_t [COLS-1:0]      data_o;
    logic  [COLS-1:0]      data_ready_i;
    bitstream_t            bitstream_i;
    logic                  bitstream_enable_i;
    logic                  execute_i;

    integer seed;
    int     errors;
    int     cycles;
    logic   done;
    data_t  send_q [COLS][$];
    data_t  exp_q  [COLS][$];

    cgra_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) cgra_top_inst (
        .clk                (clk),
        .rst_n_bs           (rst_n_bs),
        .data_i             (data_i),
        .data_ready_o       (data_ready_o),
        .data_o             (data_o),
        .data_ready_i       (data_ready_i),
        .bitstream_i        (bitstream_i),
        .bitstream_enable_i (bitstream_enable_i),
        .execute_i          (execute_i)
    );

    `include "tb_cgra_tasks.svh"

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, outputs never completed", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic reset_state();
        data_t w;
        execute_i = 1'b1;
        for (int c = 0; c < COLS; c++) begin
            w = $random(seed);
            data_i[c].valid = 1'b1;
            data_i[c].data  = w;
        end
        repeat (4) @(negedge clk);
        #2;
        for (int c = 0; c < COLS; c++) begin
            check_bit($sformatf("data_o[%0d].valid", c), data_o[c].valid, 1'b0);
            check_bit($sformatf("data_ready_o[%0d]", c), data_ready_o[c], 1'b0);
        end
        data_i = '0;
    endtask

    task automatic pass_column(input int n);
        data_t w;
        for (int r = 0; r < ROWS; r++) begin
            configure_pe(r * COLS, OP_PASS, ASEL_NORTH, BSEL_NORTH, DIR_SOUTH, '0);
        end
        for (int i = 0; i < n; i++) begin
            w = $random(seed);
            send_q[0].push_back(w);
            exp_q[0].push_back(w);
        end
        fork
            send_column(0);
            expect_column(0, n);
        join
    endtask

    task automatic imm_arith();
        data_t w;
        int    imm_val [4];
        imm_val = '{100, -7, -32767, -3};
        configure_pe(1, OP_ADD, ASEL_NORTH, BSEL_IMM, DIR_SOUTH, imm_t'(imm_val[0]));
        configure_pe(5, OP_SUB, ASEL_NORTH, BSEL_IMM, DIR_SOUTH, imm_t'(imm_val[1]));
        configure_pe(9, OP_XOR, ASEL_NORTH, BSEL_IMM, DIR_SOUTH, imm_t'(imm_val[2]));
        configure_pe(13, OP_MUL, ASEL_NORTH, BSEL_IMM, DIR_SOUTH, imm_t'(imm_val[3]));
        for (int i = 0; i < 16; i++) begin
            w = $random(seed);
            send_q[1].push_back(w);
            exp_q[1].push_back(data_t'((((w + imm_val[0]) - imm_val[1]) ^ imm_val[2])
                                       * imm_val[3]));
        end
        fork
            send_column(1);
            expect_column(1, 16);
        join
    endtask

    task automatic west_join();
        data_t a;
        data_t b;
        configure_pe(0, OP_PASS, ASEL_NORTH, BSEL_NORTH, DIR_EAST, '0);
        configure_pe(1, OP_ADD, ASEL_NORTH, BSEL_WEST, DIR_SOUTH, '0);
        for (int r = 1; r < ROWS; r++) begin
            configure_pe(r * COLS + 1, OP_PASS, ASEL_NORTH, BSEL_NORTH, DIR_SOUTH, '0);
        end
        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            b = $random(seed);
            send_q[0].push_back(a);
            send_q[1].push_back(b);
            exp_q[1].push_back(a + b);
        end
        fork
            send_column(0);
            send_column(1);
            expect_column(1, 16);
        join
    endtask

    task automatic back_pressure();
        done = 1'b0;
        fork
            begin
                pass_column(50);
                done = 1'b1;
            end
            begin
                // Random ready until the stream is complete
                while (!done) begin
                    @(negedge clk);
                    data_ready_i[0] = 1'($random(seed));
                end
            end
        join
        data_ready_i = '1;
    endtask

    task automatic execute_hold();
        fork
            pass_column(30);
            begin
                repeat (10) @(negedge clk);
                execute_i = 1'b0;
                repeat (12) begin
                    #2;
                    for (int c = 0; c < COLS; c++) begin
                        check_bit($sformatf("data_o[%0d].valid", c), data_o[c].valid, 1'b0);
                        check_bit($sformatf("data_ready_o[%0d]", c), data_ready_o[c], 1'b0);
                    end
                    @(negedge clk);
                end
                execute_i = 1'b1;
            end
        join
    endtask

    initial begin
        seed               = 22;
        errors             = 0;
        cycles             = 0;
        done               = 1'b0;
        clk                = 1'b0;
        rst_n_bs           = 1'b0;
        data_i             = '0;
        data_ready_i       = '1;
        bitstream_i        = '0;
        bitstream_enable_i = 1'b0;
        execute_i          = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_bs = 1'b1;

        reset_state();
        pass_column(20);
        imm_arith();
        west_join();
        back_pressure();
        execute_hold();
        repeat (4) @(negedge clk);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
cgra_data_pkg.sv
cgra_cfg_pkg.sv
cgra_pe_alu.sv
cgra_pe.sv
cgra_cfg_decoder.sv
cgra_top.sv
tb_cgra_top.sv

// File: Makefile
# Verilator build and run of the CGRA testbench

VERILATOR ?= verilator
TOP       ?= tb_cgra_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
